// File: Makefile
.PHONY: all compile run clean

LOG = sim.log

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module busCpu_tb -o busCpu_sim

run: compile
	./obj_dir/busCpu_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: busAlu.sv
`timescale 1ns/1ps
`default_nettype none

`include "busCpu_defines.svh"

// Z value from Y and the bus
module busAlu (
    input  busCpu_pkg::opcodeT  op,
    input  logic [`WORD_W-1:0]  y,
    input  logic [`WORD_W-1:0]  b,
    output logic [`WORD_W-1:0]  z
);

    always_comb begin
        case (op)
            busCpu_pkg::opSub: begin
                z = y - b;            // rb - rc
            end
            busCpu_pkg::opAnd: begin
                z = y & b;
            end
            busCpu_pkg::opOr: begin
                z = y | b;
            end
            default: begin
                // add, plus the address sums of ld/st and addi
                z = y + b;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: busCpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "busCpu_defines.svh"

module busCpu (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                loadEn,
    input  logic [`MEM_AW-1:0]  loadAddr,
    input  logic [`WORD_W-1:0]  loadData,
    input  logic [`MEM_AW-1:0]  peekAddr,
    output logic [`WORD_W-1:0]  peekData,
    output logic                running,
    output logic                halted
);

    busCpu_pkg::ctrlT   ctrl;
    busCpu_pkg::instrT  ir;
    logic [2:0]         step;
    logic               stepClear;
    logic               clearPc;
    logic [`MEM_AW-1:0] mar;
    logic [`WORD_W-1:0] mdr;
    logic [`WORD_W-1:0] memData;

    controlSequencer controlSequencer_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .ir        (ir),
        .step      (step),
        .ctrl      (ctrl),
        .stepClear (stepClear),
        .clearPc   (clearPc),
        .running   (running),
        .halted    (halted)
    );

    stepCounter stepCounter_inst (
        .clk   (clk),
        .reset (reset),
        .clear (stepClear),
        .step  (step)
    );

    busDatapath busDatapath_inst (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .clearPc (clearPc),
        .memData (memData),
        .ir      (ir),
        .mar     (mar),
        .mdr     (mdr)
    );

    // Load port is locked out while a program runs
    wordMemory wordMemory_inst (
        .clk      (clk),
        .ctrl     (ctrl),
        .mar      (mar),
        .mdr      (mdr),
        .data     (memData),
        .loadEn   (loadEn && !running),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .peekAddr (peekAddr),
        .peekData (peekData)
    );

endmodule

`default_nettype wire

// File: busCpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// Strobe and bus ownership rules of the sequencer
module busCpu_asserts (
    input logic                  clk,
    input logic                  reset,
    input busCpu_pkg::ctrlT      ctrl,
    input busCpu_pkg::seqStateT  state
);

    int failures = 0;                     // Read by the testbench at the end

    oneBusDriver: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.pcOut, ctrl.zLowOut, ctrl.mdrOut, ctrl.cOut, ctrl.rOut, ctrl.baOut}))
    else begin
        $error("More than one bus driver active");
        failures++;
    end

    // Nothing moves outside sRun
    quietWhenStopped: assert property (@(posedge clk) disable iff (reset)
        (state != busCpu_pkg::sRun) |-> (ctrl == '0))
    else begin
        $error("Strobe active while not running");
        failures++;
    end

    writeWithMdr: assert property (@(posedge clk) disable iff (reset)
        ctrl.write |-> ctrl.mdrIn)
    else begin
        $error("Memory write without mdrIn");
        failures++;
    end

endmodule

bind controlSequencer busCpu_asserts controlAsserts (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .state (state)
);

`default_nettype wire

// File: busCpu_defines.svh
`ifndef BUSCPU_DEFINES_SVH
`define BUSCPU_DEFINES_SVH

// Datapath word and bus width
`define WORD_W 32

// General register file size, R0 doubles as the zero base
`define REG_COUNT 16

// Word memory, addressed by the low MAR bits
`define MEM_DEPTH 512
`define MEM_AW 9

// Signed constant field of the immediate format
`define IMM_W 19

`endif

// File: busCpu_pkg.sv
`default_nettype none

`include "busCpu_defines.svh"

package busCpu_pkg;

    // Opcode sits in IR[31:27]
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opHalt = 5'b11011
    } opcodeT;

    // ld, st, addi
    typedef struct packed {
        opcodeT                          opcode;
        logic [$clog2(`REG_COUNT)-1:0] ra;
        logic [$clog2(`REG_COUNT)-1:0] rb;
        logic signed [`IMM_W-1:0]       c;
    } immFormT;

    // add, sub, and, or
    typedef struct packed {
        opcodeT                          opcode;
        logic [$clog2(`REG_COUNT)-1:0] ra;
        logic [$clog2(`REG_COUNT)-1:0] rb;
        logic [$clog2(`REG_COUNT)-1:0] rc;
        logic [14:0]                     unused;
    } regFormT;

    typedef union packed {
        immFormT imm;
        regFormT rr;
    } instrT;

    // One step worth of control strobes
    typedef struct packed {
        logic   pcOut, zLowOut, mdrOut, cOut, rOut, baOut;   // Bus drivers
        logic   pcIn, irIn, yIn, zIn, marIn, mdrIn, rIn;     // Register loads
        logic   read, write;
        logic   gra, grb, grc;                               // Field selects
        logic   incPc;                                       // Z gets bus + 1
        opcodeT aluOp;
    } ctrlT;

    typedef enum logic [1:0] {
        sIdle,
        sRun,
        sHalted
    } seqStateT;

endpackage

`default_nettype wire

// File: busCpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "busCpu_defines.svh"

module busCpu_tb;

    localparam int runLimit = 300;        // Cycles allowed from start to halted

    logic                clk;
    logic                reset;
    logic                start;
    logic                loadEn;
    logic [`MEM_AW-1:0]  loadAddr;
    logic [`WORD_W-1:0]  loadData;
    logic [`MEM_AW-1:0]  peekAddr;
    logic [`WORD_W-1:0]  peekData;
    logic                running;
    logic                halted;

    integer              seed;
    int                  errors;
    int                  checks;
    logic [`WORD_W-1:0]  prog [$];        // Word i of the program image goes to address i

    busCpu busCpu_inst (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .peekAddr (peekAddr),
        .peekData (peekData),
        .running  (running),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model and program building
    ////////////////////////////////////////////////////////////

    function automatic logic [`WORD_W-1:0] signExtend(logic [`IMM_W-1:0] c);
        return {{(`WORD_W-`IMM_W){c[`IMM_W-1]}}, c};
    endfunction

    function automatic logic [`WORD_W-1:0] fillPattern(logic [`MEM_AW-1:0] a);
        return {7'h35, a, 7'h4a, ~a};
    endfunction

    function automatic logic [`IMM_W-1:0] randomImm();
        logic [`WORD_W-1:0] r;
        r = $random(seed);
        return r[`IMM_W-1:0];
    endfunction

    // Cycles per instruction including fetch
    function automatic int instrCycles(logic [`WORD_W-1:0] w);
        case (w[31:27])
            busCpu_pkg::opLd:   return 8;
            busCpu_pkg::opSt:   return 7;
            busCpu_pkg::opHalt: return 4;
            default:            return 6;   // addi and register ALU ops
        endcase
    endfunction

    function automatic int programCycles();
        int total;
        total = 0;
        foreach (prog[i]) begin
            total += instrCycles(prog[i]);  // Straight-line code ending in halt
        end
        return total;
    endfunction

    task automatic pushImm(busCpu_pkg::opcodeT op, logic [3:0] ra, logic [3:0] rb,
            logic [`IMM_W-1:0] c);
        prog.push_back({op, ra, rb, c});
    endtask

    task automatic pushReg(busCpu_pkg::opcodeT op, logic [3:0] ra, logic [3:0] rb,
            logic [3:0] rc);
        prog.push_back({op, ra, rb, rc, 15'd0});
    endtask

    ////////////////////////////////////////////////////////////
    // Bus-level helpers
    ////////////////////////////////////////////////////////////

    task automatic applyReset();
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic writeWord(logic [`MEM_AW-1:0] addr, logic [`WORD_W-1:0] data);
        @(negedge clk);
        loadEn   = 1'b1;
        loadAddr = addr;
        loadData = data;
        @(negedge clk);
        loadEn   = 1'b0;
    endtask

    task automatic loadProgram();
        foreach (prog[i]) begin
            writeWord(`MEM_AW'(i), prog[i]);
        end
    endtask

    task automatic fillMemory();
        for (int a = 'h40; a < `MEM_DEPTH; a++) begin
            writeWord(`MEM_AW'(a), fillPattern(`MEM_AW'(a)));
        end
    endtask

    task automatic peekWord(logic [`MEM_AW-1:0] addr, output logic [`WORD_W-1:0] data);
        @(negedge clk);
        peekAddr = addr;
        #1;                                 // Combinational read settles
        data = peekData;
    endtask

    task automatic expectWord(logic [`MEM_AW-1:0] addr, logic [`WORD_W-1:0] expected,
            string what);
        logic [`WORD_W-1:0] got;
        peekWord(addr, got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %0t: %s at 0x%03h, got 0x%08h, expected 0x%08h",
                $time, what, addr, got, expected);
        end
    endtask

    // Pulse start and count cycles until halted while optionally hammering the load port
    task automatic runProgram(bit lockLoad, logic [`MEM_AW-1:0] lockAddr);
        int                 cycles;
        int                 expected;
        logic [`WORD_W-1:0] r;
        expected = programCycles();
        cycles   = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);                     // Rising edge in between samples start
        start = 1'b0;
        while (!halted && cycles < runLimit) begin
            checks++;
            if (!running) begin
                errors++;
                $display("ERR %0t: running low before halted, cycle %0d", $time, cycles);
            end
            if (lockLoad) begin
                r        = $random(seed);
                loadEn   = 1'b1;
                loadAddr = lockAddr;
                loadData = r;
            end
            @(negedge clk);
            cycles++;
        end
        loadEn = 1'b0;
        if (!halted) begin
            errors++;
            $display("Timeout: halted did not rise within %0d cycles of start", runLimit);
        end else begin
            checks += 2;
            if (cycles != expected) begin
                errors++;
                $display("ERR %0t: halted after %0d cycles, expected %0d",
                    $time, cycles, expected);
            end
            if (running) begin
                errors++;
                $display("ERR %0t: running still high while halted", $time);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic storeLoadTest();
        logic [`IMM_W-1:0] v;
        v = randomImm();
        applyReset();
        prog.delete();
        pushImm(busCpu_pkg::opAddi, 4'd4, 4'd0, v);
        pushImm(busCpu_pkg::opSt,   4'd4, 4'd0, 19'h090);
        pushImm(busCpu_pkg::opLd,   4'd0, 4'd0, 19'h090);   // R0 as target
        pushImm(busCpu_pkg::opSt,   4'd0, 4'd0, 19'h091);
        pushImm(busCpu_pkg::opHalt, 4'd0, 4'd0, 19'h0);
        loadProgram();
        runProgram(1'b0, '0);
        expectWord(9'h090, signExtend(v), "st from R4");
        expectWord(9'h091, signExtend(v), "st from R0 after ld");
    endtask

    task automatic baseAddressTest();
        logic [`IMM_W-1:0]  v1;
        logic [`IMM_W-1:0]  v2;
        logic [`IMM_W-1:0]  v3;
        logic [`IMM_W-1:0]  base;
        logic [`WORD_W-1:0] r;
        logic [`MEM_AW-1:0] upAddr;
        logic [`MEM_AW-1:0] downAddr;
        v1       = randomImm();
        v2       = randomImm();
        v3       = randomImm();
        r        = $random(seed);
        base     = 19'h100 + {13'h0, r[5:0]};
        upAddr   = base[`MEM_AW-1:0] + 9'h020;
        downAddr = base[`MEM_AW-1:0] - 9'h010;
        applyReset();
        prog.delete();
        pushImm(busCpu_pkg::opAddi, 4'd1, 4'd0, v1);
        pushImm(busCpu_pkg::opSt,   4'd1, 4'd0, 19'h0a0);  // Absolute through R0
        pushImm(busCpu_pkg::opAddi, 4'd2, 4'd0, base);
        pushImm(busCpu_pkg::opAddi, 4'd3, 4'd0, v2);
        pushImm(busCpu_pkg::opAddi, 4'd5, 4'd0, v3);
        pushImm(busCpu_pkg::opSt,   4'd3, 4'd2, 19'h00020);
        pushImm(busCpu_pkg::opSt,   4'd5, 4'd2, 19'h7fff0);  // C = -16
        pushImm(busCpu_pkg::opHalt, 4'd0, 4'd0, 19'h0);
        loadProgram();
        runProgram(1'b0, '0);
        expectWord(9'h0a0, signExtend(v1), "st C(R0)");
        expectWord(9'h09f, fillPattern(9'h09f), "word below C(R0)");
        expectWord(9'h0a1, fillPattern(9'h0a1), "word above C(R0)");
        expectWord(upAddr, signExtend(v2), "st +C(rb)");
        expectWord(upAddr - 9'd1, fillPattern(upAddr - 9'd1), "word below +C(rb)");
        expectWord(upAddr + 9'd1, fillPattern(upAddr + 9'd1), "word above +C(rb)");
        expectWord(downAddr, signExtend(v3), "st -C(rb)");
        expectWord(downAddr - 9'd1, fillPattern(downAddr - 9'd1), "word below -C(rb)");
        expectWord(downAddr + 9'd1, fillPattern(downAddr + 9'd1), "word above -C(rb)");
    endtask

    task automatic aluTest();
        logic [`IMM_W-1:0]  imm [4];
        logic [`WORD_W-1:0] a;
        logic [`WORD_W-1:0] b;
        foreach (imm[i]) begin
            imm[i] = randomImm();
        end
        a = signExtend(imm[0]) + signExtend(imm[1]);
        b = signExtend(imm[2]) + signExtend(imm[3]);
        applyReset();
        prog.delete();
        pushImm(busCpu_pkg::opAddi, 4'd1, 4'd0, imm[0]);
        pushImm(busCpu_pkg::opAddi, 4'd1, 4'd1, imm[1]);   // Accumulate into R1
        pushImm(busCpu_pkg::opAddi, 4'd2, 4'd0, imm[2]);
        pushImm(busCpu_pkg::opAddi, 4'd2, 4'd2, imm[3]);
        pushReg(busCpu_pkg::opAdd,  4'd3, 4'd1, 4'd2);
        pushReg(busCpu_pkg::opSub,  4'd4, 4'd1, 4'd2);
        pushReg(busCpu_pkg::opAnd,  4'd5, 4'd1, 4'd2);
        pushReg(busCpu_pkg::opOr,   4'd6, 4'd1, 4'd2);
        pushImm(busCpu_pkg::opSt,   4'd3, 4'd0, 19'h0c0);
        pushImm(busCpu_pkg::opSt,   4'd4, 4'd0, 19'h0c1);
        pushImm(busCpu_pkg::opSt,   4'd5, 4'd0, 19'h0c2);
        pushImm(busCpu_pkg::opSt,   4'd6, 4'd0, 19'h0c3);
        pushImm(busCpu_pkg::opHalt, 4'd0, 4'd0, 19'h0);
        loadProgram();
        runProgram(1'b0, '0);
        expectWord(9'h0c0, a + b, "add result");
        expectWord(9'h0c1, a - b, "sub result");
        expectWord(9'h0c2, a & b, "and result");
        expectWord(9'h0c3, a | b, "or result");
    endtask

    // Mixed program with every instruction class once
    task automatic timingTest();
        logic [`IMM_W-1:0]  v;
        logic [`WORD_W-1:0] a;
        v = randomImm();
        a = signExtend(v);
        applyReset();
        prog.delete();
        pushImm(busCpu_pkg::opAddi, 4'd1, 4'd0, v);
        pushImm(busCpu_pkg::opSt,   4'd1, 4'd0, 19'h180);
        pushImm(busCpu_pkg::opLd,   4'd2, 4'd0, 19'h180);
        pushReg(busCpu_pkg::opAdd,  4'd3, 4'd1, 4'd2);
        pushReg(busCpu_pkg::opSub,  4'd4, 4'd3, 4'd1);
        pushReg(busCpu_pkg::opAnd,  4'd5, 4'd3, 4'd4);
        pushReg(busCpu_pkg::opOr,   4'd6, 4'd5, 4'd1);
        pushImm(busCpu_pkg::opSt,   4'd6, 4'd0, 19'h181);
        pushImm(busCpu_pkg::opHalt, 4'd0, 4'd0, 19'h0);
        loadProgram();
        runProgram(1'b0, '0);
        expectWord(9'h181, ((a + a) & a) | a, "mixed program result");
    endtask

    task automatic restartTest();
        logic [`IMM_W-1:0]  v;
        logic [`WORD_W-1:0] a;
        v = randomImm();
        a = signExtend(v);
        applyReset();
        prog.delete();
        pushImm(busCpu_pkg::opAddi, 4'd1, 4'd0, v);
        pushImm(busCpu_pkg::opSt,   4'd1, 4'd0, 19'h0d0);
        pushImm(busCpu_pkg::opLd,   4'd2, 4'd0, 19'h0d0);
        pushReg(busCpu_pkg::opAdd,  4'd3, 4'd2, 4'd1);
        pushImm(busCpu_pkg::opSt,   4'd3, 4'd0, 19'h0d1);
        pushImm(busCpu_pkg::opHalt, 4'd0, 4'd0, 19'h0);
        loadProgram();
        expectWord(9'h1e0, fillPattern(9'h1e0), "data word before locked load");
        runProgram(1'b1, 9'h1e0);
        expectWord(9'h1e0, fillPattern(9'h1e0), "data word after locked load");
        expectWord(9'h0d0, a, "first run st");
        expectWord(9'h0d1, a + a, "first run sum");
        writeWord(9'h0d0, '0);              // Load port is open again once halted
        writeWord(9'h0d1, '0);
        expectWord(9'h0d0, '0, "load while halted");
        runProgram(1'b1, 9'h000);           // Second start without a reset in between
        expectWord(9'h000, prog[0], "program word after locked load");
        expectWord(9'h0d0, a, "second run st");
        expectWord(9'h0d1, a + a, "second run sum");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed     = 32'h982b8f2e;
        errors   = 0;
        checks   = 0;
        reset    = 1'b1;
        start    = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        peekAddr = '0;
        applyReset();
        fillMemory();
        storeLoadTest();
        baseAddressTest();
        repeat (3) aluTest();
        timingTest();
        restartTest();
        errors += busCpu_inst.controlSequencer_inst.controlAsserts.failures;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)", checks, errors,
            busCpu_inst.controlSequencer_inst.controlAsserts.failures);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: busDatapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "busCpu_defines.svh"

module busDatapath (
    input  logic                clk,
    input  logic                reset,
    input  busCpu_pkg::ctrlT    ctrl,
    input  logic                clearPc,
    input  logic [`WORD_W-1:0]  memData,
    output busCpu_pkg::instrT   ir,
    output logic [`MEM_AW-1:0]  mar,
    output logic [`WORD_W-1:0]  mdr
);

    logic [`WORD_W-1:0] bus;
    logic [`WORD_W-1:0] pc;
    logic [`WORD_W-1:0] y;
    logic [`WORD_W-1:0] z;
    logic [`WORD_W-1:0] mdrQ;
    logic [`WORD_W-1:0] mdrNext;
    logic [`WORD_W-1:0] aluZ;
    logic [`WORD_W-1:0] regOut;
    logic [`WORD_W-1:0] cExt;

    assign cExt = {{(`WORD_W-`IMM_W){ir.imm.c[`IMM_W-1]}}, ir.imm.c};

    ////////////////////////////////////////////////////////////
    // Shared bus
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (ctrl.pcOut) begin
            bus = pc;
        end else if (ctrl.zLowOut) begin
            bus = z;
        end else if (ctrl.mdrOut) begin
            bus = mdrQ;
        end else if (ctrl.cOut) begin
            bus = cExt;
        end else if (ctrl.rOut || ctrl.baOut) begin
            bus = regOut;
        end else begin
            bus = '0;                 // Nobody drives
        end
    end

    assign mdrNext = ctrl.read ? memData : bus;
    // Memory sees the word MDR takes this cycle, which lets st write in T6
    assign mdr     = ctrl.mdrIn ? mdrNext : mdrQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (clearPc) begin
                pc <= '0;
            end else if (ctrl.pcIn) begin
                pc <= bus;
            end
            if (ctrl.irIn) begin
                ir <= busCpu_pkg::instrT'(bus);
            end
        end
    end

    // Operand and address registers
    always_ff @(posedge clk) begin
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= ctrl.incPc ? bus + 1'b1 : aluZ;   // T0 forms PC + 1
        end
        if (ctrl.marIn) begin
            mar <= bus[`MEM_AW-1:0];
        end
        if (ctrl.mdrIn) begin
            mdrQ <= mdrNext;
        end
    end

    registerFile registerFile_inst (
        .clk    (clk),
        .reset  (reset),
        .ir     (ir),
        .gra    (ctrl.gra),
        .grb    (ctrl.grb),
        .grc    (ctrl.grc),
        .rIn    (ctrl.rIn),
        .baOut  (ctrl.baOut),
        .busIn  (bus),
        .regOut (regOut)
    );

    busAlu busAlu_inst (
        .op (ctrl.aluOp),
        .y  (y),
        .b  (bus),
        .z  (aluZ)
    );

endmodule

`default_nettype wire

// File: controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  busCpu_pkg::instrT  ir,
    input  logic [2:0]         step,
    output busCpu_pkg::ctrlT   ctrl,
    output logic               stepClear,
    output logic               clearPc,
    output logic               running,
    output logic               halted
);

    busCpu_pkg::seqStateT state;
    busCpu_pkg::opcodeT   op;
    logic                 lastStep;
    logic                 haltNow;

    assign op        = ir.imm.opcode;
    assign running   = (state == busCpu_pkg::sRun);
    assign halted    = (state == busCpu_pkg::sHalted);
    assign stepClear = lastStep || (state != busCpu_pkg::sRun);

    ////////////////////////////////////////////////////////////
    // Run state
    ////////////////////////////////////////////////////////////

    // PC is held at zero while stopped so every run starts at word 0
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= busCpu_pkg::sIdle;
            clearPc <= 1'b1;
        end else begin
            case (state)
                busCpu_pkg::sRun: begin
                    if (haltNow) begin
                        state   <= busCpu_pkg::sHalted;
                        clearPc <= 1'b1;
                    end
                end
                default: begin        // Idle or halted
                    if (start) begin
                        state   <= busCpu_pkg::sRun;
                        clearPc <= 1'b0;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Step decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl     = '0;
        lastStep = 1'b0;
        haltNow  = 1'b0;
        if (state == busCpu_pkg::sRun) begin
            case (step)
                3'd0: begin           // MAR <= PC, Z <= PC + 1
                    ctrl.pcOut = 1'b1;
                    ctrl.marIn = 1'b1;
                    ctrl.incPc = 1'b1;
                    ctrl.zIn   = 1'b1;
                end
                3'd1: begin
                    ctrl.zLowOut = 1'b1;
                    ctrl.pcIn    = 1'b1;
                    ctrl.read    = 1'b1;
                    ctrl.mdrIn   = 1'b1;
                end
                3'd2: begin
                    ctrl.mdrOut = 1'b1;
                    ctrl.irIn   = 1'b1;
                end
                default: begin
                    case (op)
                        busCpu_pkg::opLd, busCpu_pkg::opSt: begin
                            case (step)
                                3'd3: begin   // Y <= base, R0 reads as zero
                                    ctrl.grb   = 1'b1;
                                    ctrl.baOut = 1'b1;
                                    ctrl.yIn   = 1'b1;
                                end
                                3'd4: begin
                                    ctrl.cOut  = 1'b1;
                                    ctrl.aluOp = busCpu_pkg::opAdd;
                                    ctrl.zIn   = 1'b1;
                                end
                                3'd5: begin
                                    ctrl.zLowOut = 1'b1;
                                    ctrl.marIn   = 1'b1;
                                end
                                3'd6: begin
                                    ctrl.mdrIn = 1'b1;
                                    if (op == busCpu_pkg::opSt) begin
                                        ctrl.gra   = 1'b1;
                                        ctrl.rOut  = 1'b1;
                                        ctrl.write = 1'b1;
                                        lastStep   = 1'b1;
                                    end else begin
                                        ctrl.read = 1'b1;
                                    end
                                end
                                default: begin    // T7, ld only
                                    ctrl.mdrOut = 1'b1;
                                    ctrl.gra    = 1'b1;
                                    ctrl.rIn    = 1'b1;
                                    lastStep    = 1'b1;
                                end
                            endcase
                        end
                        busCpu_pkg::opAddi, busCpu_pkg::opAdd, busCpu_pkg::opSub,
                        busCpu_pkg::opAnd, busCpu_pkg::opOr: begin
                            case (step)
                                3'd3: begin
                                    ctrl.grb  = 1'b1;
                                    ctrl.rOut = 1'b1;
                                    ctrl.yIn  = 1'b1;
                                end
                                3'd4: begin
                                    ctrl.zIn = 1'b1;
                                    if (op == busCpu_pkg::opAddi) begin
                                        ctrl.cOut  = 1'b1;
                                        ctrl.aluOp = busCpu_pkg::opAdd;
                                    end else begin
                                        ctrl.grc   = 1'b1;
                                        ctrl.rOut  = 1'b1;
                                        ctrl.aluOp = op;
                                    end
                                end
                                default: begin    // T5 writeback
                                    ctrl.zLowOut = 1'b1;
                                    ctrl.gra     = 1'b1;
                                    ctrl.rIn     = 1'b1;
                                    lastStep     = 1'b1;
                                end
                            endcase
                        end
                        default: begin        // halt, unknown opcodes stop too
                            haltNow  = 1'b1;
                            lastStep = 1'b1;
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "busCpu_defines.svh"

module registerFile (
    input  logic                clk,
    input  logic                reset,
    input  busCpu_pkg::instrT   ir,
    input  logic                gra,
    input  logic                grb,
    input  logic                grc,
    input  logic                rIn,
    input  logic                baOut,
    input  logic [`WORD_W-1:0]  busIn,
    output logic [`WORD_W-1:0]  regOut
);

    logic [`WORD_W-1:0]             regs [`REG_COUNT];
    logic [$clog2(`REG_COUNT)-1:0] idx;

    ////////////////////////////////////////////////////////////
    // Select and encode
    ////////////////////////////////////////////////////////////

    // Only one of gra/grb/grc is raised per step
    always_comb begin
        idx = '0;
        if (gra) begin
            idx = ir.imm.ra;
        end else if (grb) begin
            idx = ir.imm.rb;
        end else if (grc) begin
            idx = ir.rr.rc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[idx] <= busIn;
        end
    end

    // Base reads of R0 give zero, so C(R0) is an absolute address
    assign regOut = (baOut && idx == '0) ? '0 : regs[idx];

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
busCpu_pkg.sv
stepCounter.sv
controlSequencer.sv
registerFile.sv
busAlu.sv
busDatapath.sv
wordMemory.sv
busCpu.sv
busCpu_asserts.sv
busCpu_tb.sv

// File: stepCounter.sv
`timescale 1ns/1ps
`default_nettype none

// T-step index within the current instruction
module stepCounter (
    input  logic       clk,
    input  logic       reset,
    input  logic       clear,
    output logic [2:0] step
);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            step <= 3'd0;             // Next cycle is T0
        end else begin
            step <= step + 3'd1;
        end
    end

endmodule

`default_nettype wire

// File: wordMemory.sv
`timescale 1ns/1ps
`default_nettype none

`include "busCpu_defines.svh"

module wordMemory (
    input  logic                clk,
    input  busCpu_pkg::ctrlT    ctrl,
    input  logic [`MEM_AW-1:0]  mar,
    input  logic [`WORD_W-1:0]  mdr,
    output logic [`WORD_W-1:0]  data,
    input  logic                loadEn,
    input  logic [`MEM_AW-1:0]  loadAddr,
    input  logic [`WORD_W-1:0]  loadData,
    input  logic [`MEM_AW-1:0]  peekAddr,
    output logic [`WORD_W-1:0]  peekData
);

    logic [`WORD_W-1:0] mem [`MEM_DEPTH];

    // CPU store wins over the load port
    always_ff @(posedge clk) begin
        if (ctrl.write) begin
            mem[mar] <= mdr;
        end else if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign data     = mem[mar];
    assign peekData = mem[peekAddr];  // Debug read, any time

endmodule

`default_nettype wire
